//--- build.f
+incdir+.
rv_isa_pkg.sv
rv_core_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_pc_unit.sv
rv_core.sv
tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - rv_isa_pkg.sv
  - rv_core_pkg.sv
  - rv_decode.sv
  - rv_regfile.sv
  - rv_execute.sv
  - rv_pc_unit.sv
  - rv_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_core.sv

//--- tb_rv_model.svh
/* Reference ISA model for the kept RV32I subset, included inside tb_rv_core after
   the package imports. Unknown opcodes write nothing and advance pc by 4. */
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// architectural state of the model
logic [xlen-1:0] regs_model [32];
logic [xlen-1:0] pc_model;

// same state as after reset
task automatic clear_model();
    for (int i = 0; i < 32; i++) begin
        regs_model[i] = '0;
    end
    pc_model = '0;
endtask

// register and immediate alu, alt selects sub and sra
function automatic logic [xlen-1:0] alu_result(input logic [2:0] f3, input logic alt,
                                               input logic [xlen-1:0] a,
                                               input logic [xlen-1:0] b);
    logic [xlen-1:0] r;
    case (f3)
        3'b000: r = alt ? a - b : a + b;
        3'b001: r = a << b[4:0];
        3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: r = (a < b) ? 32'd1 : 32'd0;
        3'b100: r = a ^ b;
        3'b101: begin
            // kept apart so the arithmetic shift stays signed
            if (alt) begin
                r = $signed(a) >>> b[4:0];
            end else begin
                r = a >> b[4:0];
            end
        end
        3'b110: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// branch condition from funct3
function automatic logic branch_taken(input logic [2:0] f3, input logic [xlen-1:0] a,
                                      input logic [xlen-1:0] b);
    case (f3)
        3'b000: return a == b;
        3'b001: return a != b;
        3'b100: return $signed(a) < $signed(b);
        3'b101: return $signed(a) >= $signed(b);
        3'b110: return a < b;
        3'b111: return a >= b;
        default: return 1'b0;
    endcase
endfunction

// expected retire and next pc of one instruction
task automatic predict_instr(input logic [xlen-1:0] instr, output retire_t exp,
                             output logic [xlen-1:0] npc);
    logic [2:0]      f3;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_b;
    logic            wr;
    logic [xlen-1:0] val;
    f3 = instr[14:12];
    a = regs_model[instr[19:15]];
    b = regs_model[instr[24:20]];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_u = {instr[31:12], 12'h000};
    imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    wr = 1'b0;
    val = '0;
    npc = pc_model + 32'd4;
    case (instr[6:0])
        opc_op: begin
            wr = 1'b1;
            val = alu_result(f3, instr[30], a, b);
        end
        opc_op_imm: begin
            // only srai uses bit 30, addi never subtracts
            wr = 1'b1;
            val = alu_result(f3, instr[30] && (f3 == 3'b101), a, imm_i);
        end
        opc_lui: begin
            wr = 1'b1;
            val = imm_u;
        end
        opc_auipc: begin
            wr = 1'b1;
            val = pc_model + imm_u;
        end
        opc_jal: begin
            wr = 1'b1;
            val = pc_model + 32'd4;
            npc = pc_model + imm_j;
        end
        opc_jalr: begin
            wr = 1'b1;
            val = pc_model + 32'd4;
            npc = (a + imm_i) & ~32'd1;
        end
        opc_branch: begin
            if (branch_taken(f3, a, b)) begin
                npc = pc_model + imm_b;
            end
        end
        default: begin
            wr = 1'b0;
        end
    endcase
    exp.wen = wr && (instr[11:7] != 5'd0);
    exp.rd = instr[11:7];
    exp.data = val;
endtask

// x0 never written, so it keeps reading zero
task automatic commit_instr(input retire_t exp, input logic [xlen-1:0] npc);
    if (exp.wen) begin
        regs_model[exp.rd] = exp.data;
    end
    pc_model = npc;
endtask

`endif

//--- tb_rv_core.sv
/* Random single-cycle test of rv_core against an ISA model. Targets stay inside
   a 4 KB window; run length and timeout are set by the localparams below. */
`timescale 1ns/100ps

module tb_rv_core;
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    localparam int period = 100;
    localparam int reset_cycles = 5;
    localparam int num_instr = 2000;
    // run length plus some margin
    localparam int timeout_cycles = reset_cycles + num_instr + 95;

    logic            clk;
    logic            rst_n;
    logic [xlen-1:0] cmd;
    logic [xlen-1:0] pc;
    retire_t         retire;
    int              cycles = 0;

    funct3_branch_e branch_conds [6] = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};

    `include "tb_rv_model.svh"

    rv_core i_rv_core (
        .clk    (clk),
        .rst_n  (rst_n),
        .cmd    (cmd),
        .pc     (pc),
        .retire (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    task automatic stop_on_error();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_pc(input logic [xlen-1:0] exp, input logic [xlen-1:0] act);
        if (act !== exp) begin
            $display("ERROR %0t pc expected %h actual %h", $time, exp, act);
            stop_on_error();
        end
    endtask

    // rd and data only matter when a write is expected
    task automatic check_retire(input retire_t exp, input retire_t act);
        logic bad;
        bad = act.wen !== exp.wen;
        if (exp.wen && (act.rd !== exp.rd || act.data !== exp.data)) begin
            bad = 1'b1;
        end
        if (bad) begin
            $display("ERROR %0t retire expected wen=%b rd=%0d data=%h actual wen=%b rd=%0d data=%h",
                     $time, exp.wen, exp.rd, exp.data, act.wen, act.rd, act.data);
            stop_on_error();
        end
    endtask

    // one random instruction of a kept class
    function automatic logic [xlen-1:0] make_instr();
        int              kind;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [11:0]     imm12;
        logic [xlen-1:0] tgt;
        logic [xlen-1:0] off;
        kind = $urandom_range(0, 11);
        // small register set for more dependencies, x0 included
        rd = 5'($urandom_range(0, 15));
        rs1 = 5'($urandom_range(0, 15));
        rs2 = 5'($urandom_range(0, 15));
        f3 = 3'($urandom_range(0, 7));
        tgt = xlen'($urandom_range(0, 1023)) << 2;
        off = tgt - pc_model;
        // jump back down before pc leaves the window
        if (pc_model > 32'h0000_0e00) begin
            kind = 8;
        end
        case (kind)
            0, 1, 2: begin
                f7 = 7'b0;
                if (f3 == 3'b000 || f3 == 3'b101) begin
                    f7[5] = 1'($urandom_range(0, 1));
                end
                return {f7, rs2, rs1, f3, rd, opc_op};
            end
            3, 4, 5: begin
                imm12 = 12'($urandom);
                // shifts take a 5 bit shamt, srai sets bit 30
                if (f3 == 3'b001) begin
                    imm12[11:5] = 7'b0;
                end
                if (f3 == 3'b101) begin
                    imm12[11:5] = {1'b0, imm12[10], 5'b0};
                end
                return {imm12, rs1, f3, rd, opc_op_imm};
            end
            6: return {20'($urandom), rd, opc_lui};
            7: return {20'($urandom), rd, opc_auipc};
            8: return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
            9: begin
                // odd targets check that bit 0 is cleared
                tgt = xlen'($urandom_range(0, 2047));
                off = tgt - regs_model[rs1];
                if ($signed(off) < -2048 || $signed(off) > 2047) begin
                    rs1 = '0;
                    off = tgt;
                end
                return {off[11:0], rs1, 3'b000, rd, opc_jalr};
            end
            default: begin
                // equal sources now and then so beq and bge get taken
                if ($urandom_range(0, 3) == 0) begin
                    rs2 = rs1;
                end
                f3 = branch_conds[$urandom_range(0, 5)];
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
            end
        endcase
    endfunction

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
            stop_on_error();
        end
    end

    initial begin
        retire_t         exp_ret;
        retire_t         idle_ret;
        logic [xlen-1:0] next_pc;
        logic [xlen-1:0] instr;
        void'($urandom(32'h91dec79f));
        rst_n = 1'b0;
        // addi to x1, decodes with wen set so only the reset gating holds it low
        cmd = {12'($urandom), 5'd0, 3'b000, 5'd1, opc_op_imm};
        idle_ret = '0;
        clear_model();
        // no register write may show while in reset
        repeat (reset_cycles) begin
            @(negedge clk);
            check_retire(idle_ret, retire);
        end
        rst_n = 1'b1;
        for (int n = 0; n < num_instr; n++) begin
            instr = make_instr();
            cmd = instr;
            // sample late in the cycle, outputs settled
            #(period / 2 - 10);
            predict_instr(instr, exp_ret, next_pc);
            check_pc(pc_model, pc);
            check_retire(exp_ret, retire);
            commit_instr(exp_ret, next_pc);
            @(negedge clk);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- rv_core.sv
/* Single-cycle RV32I subset, one instruction per clock taken from cmd.
   No handshake; cmd is sampled every cycle and retire is valid in the same cycle. */
`timescale 1ns/100ps

module rv_core (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [rv_isa_pkg::xlen-1:0] cmd,
    output logic [rv_isa_pkg::xlen-1:0] pc,
    output rv_core_pkg::retire_t        retire
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] result;
    logic            taken;

    // decode stage
    rv_decode i_decode (
        .cmd  (cmd),
        .ctrl (ctrl),
        .imm  (imm)
    );

    // register read, sources from fixed fields
    // write back of the alu result on the next edge
    rv_regfile i_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (cmd[rs1_lsb +: reg_addr_w]),
        .raddr_b (cmd[rs2_lsb +: reg_addr_w]),
        .waddr   (ctrl.rd),
        .wen     (ctrl.wen),
        .wdata   (result),
        .rdata_a (rs1_val),
        .rdata_b (rs2_val)
    );

    // execute stage
    rv_execute i_execute (
        .ctrl    (ctrl),
        .imm     (imm),
        .pc      (pc),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .result  (result),
        .taken   (taken)
    );

    // pc update
    rv_pc_unit i_pc_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .pc_sel  (ctrl.pc_sel),
        .taken   (taken),
        .imm     (imm),
        .rs1_val (rs1_val),
        .pc      (pc)
    );

    // retire port, write enable held low in reset
    assign retire.wen = ctrl.wen & rst_n;
    assign retire.rd = ctrl.rd;
    assign retire.data = result;

endmodule

//--- rv_pc_unit.sv
/* Pc clears to 0 on synchronous reset and advances every cycle.
   No misaligned target check; jalr clears bit 0 only. */
`timescale 1ns/100ps

module rv_pc_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  rv_core_pkg::pc_sel_e        pc_sel,
    input  logic                        taken,
    input  logic [rv_isa_pkg::xlen-1:0] imm,
    input  logic [rv_isa_pkg::xlen-1:0] rs1_val,
    output logic [rv_isa_pkg::xlen-1:0] pc
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic [xlen-1:0] seq_pc;
    logic [xlen-1:0] rel_pc;
    logic [xlen-1:0] jalr_pc;
    logic [xlen-1:0] next_pc;

    // candidate targets
    assign seq_pc = pc + xlen'(4);
    assign rel_pc = pc + imm;
    assign jalr_pc = (rs1_val + imm) & ~xlen'(1);

    always_comb begin
        case (pc_sel)
            pc_branch: next_pc = taken ? rel_pc : seq_pc;
            pc_jal:    next_pc = rel_pc;
            pc_jalr:   next_pc = jalr_pc;
            default:   next_pc = seq_pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

//--- rv_execute.sv
/* Combinational ALU and branch compare. The taken flag is computed for every
   instruction and only means something when pc_sel selects branch. */
`timescale 1ns/100ps

module rv_execute (
    input  rv_core_pkg::ctrl_t          ctrl,
    input  logic [rv_isa_pkg::xlen-1:0] imm,
    input  logic [rv_isa_pkg::xlen-1:0] pc,
    input  logic [rv_isa_pkg::xlen-1:0] rs1_val,
    input  logic [rv_isa_pkg::xlen-1:0] rs2_val,
    output logic [rv_isa_pkg::xlen-1:0] result,
    output logic                        taken
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic [xlen-1:0]          op_a;
    logic [xlen-1:0]          op_b;
    logic [$clog2(xlen)-1:0]  shamt;
    logic                     lt_s;
    logic                     lt_u;
    logic                     br_eq;
    logic                     br_lt_s;
    logic                     br_lt_u;

    // operand select
    assign op_a = (ctrl.a_sel == a_pc) ? pc : rs1_val;

    always_comb begin
        case (ctrl.b_sel)
            b_imm:   op_b = imm;
            b_four:  op_b = xlen'(4);
            default: op_b = rs2_val;
        endcase
    end

    // low bits only, as in rv32i
    assign shamt = op_b[$clog2(xlen)-1:0];

    // set-less-than on alu operands
    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    always_comb begin
        case (ctrl.alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_sll:    result = op_a << shamt;
            alu_slt:    result = xlen'(lt_s);
            alu_sltu:   result = xlen'(lt_u);
            alu_xor:    result = op_a ^ op_b;
            alu_srl:    result = op_a >> shamt;
            alu_sra:    result = $signed(op_a) >>> shamt;
            alu_or:     result = op_a | op_b;
            alu_and:    result = op_a & op_b;
            alu_pass_b: result = op_b;
            default:    result = op_a + op_b;
        endcase
    end

    // branch compare always on the raw register values
    // operand a may be pc here, so the alu compares are not reused
    assign br_eq = rs1_val == rs2_val;
    assign br_lt_s = $signed(rs1_val) < $signed(rs2_val);
    assign br_lt_u = rs1_val < rs2_val;

    always_comb begin
        case (ctrl.br_cond)
            f3_beq:  taken = br_eq;
            f3_bne:  taken = !br_eq;
            f3_blt:  taken = br_lt_s;
            f3_bge:  taken = !br_lt_s;
            f3_bltu: taken = br_lt_u;
            f3_bgeu: taken = !br_lt_u;
            // reserved conditions fall through
            default: taken = 1'b0;
        endcase
    end

endmodule

//--- rv_regfile.sv
/* Writes to index 0 are not filtered here; the decoder must clear wen for rd x0.
   All entries clear under synchronous reset. */
`timescale 1ns/100ps

module rv_regfile (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] raddr_a,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] raddr_b,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] waddr,
    input  logic                              wen,
    input  logic [rv_isa_pkg::xlen-1:0]       wdata,
    output logic [rv_isa_pkg::xlen-1:0]       rdata_a,
    output logic [rv_isa_pkg::xlen-1:0]       rdata_b
);
    import rv_isa_pkg::*;

    // 32 entries of xlen bits
    logic [xlen-1:0] regs [2**reg_addr_w];

    // single write port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads, x0 forced to zero
    // no write-through, new value is seen next cycle
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

//--- rv_decode.sv
/* Purely combinational. Opcodes outside the kept RV32I subset decode to a
   no-write, pc plus four control word. */
`timescale 1ns/100ps

module rv_decode (
    input  logic [rv_isa_pkg::xlen-1:0] cmd,
    output rv_core_pkg::ctrl_t          ctrl,
    output logic [rv_isa_pkg::xlen-1:0] imm
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    opcode_e            opcode;
    funct3_alu_e        f3_alu;
    logic               alt;
    logic [xlen-1:0]    i_imm;
    logic [xlen-1:0]    u_imm;
    logic [xlen-1:0]    j_imm;
    logic [xlen-1:0]    br_imm;

    // funct3 to alu op
    // allow_sub is only set for register form, addi has no sub
    function automatic alu_op_e alu_op_sel(input funct3_alu_e f3, input logic alt_bit,
                                           input logic allow_sub);
        alu_op_e sel;
        case (f3)
            f3_add_sub: sel = (alt_bit && allow_sub) ? alu_sub : alu_add;
            f3_sll:     sel = alu_sll;
            f3_slt:     sel = alu_slt;
            f3_sltu:    sel = alu_sltu;
            f3_xor:     sel = alu_xor;
            f3_srl_sra: sel = alt_bit ? alu_sra : alu_srl;
            f3_or:      sel = alu_or;
            default:    sel = alu_and;
        endcase
        return sel;
    endfunction

    assign opcode = opcode_e'(cmd[opcode_w-1:0]);
    assign f3_alu = funct3_alu_e'(cmd[funct3_lsb +: funct3_w]);
    assign alt = cmd[funct7_alt_bit];

    // immediate formats, all sign extended from bit 31
    assign i_imm = {{(xlen-12){cmd[imm_sign_bit]}}, cmd[31:20]};
    assign u_imm = {cmd[31:12], 12'b0};
    assign j_imm = {{(xlen-20){cmd[imm_sign_bit]}}, cmd[19:12], cmd[20], cmd[30:21], 1'b0};
    assign br_imm = {{(xlen-12){cmd[imm_sign_bit]}}, cmd[7], cmd[30:25], cmd[11:8], 1'b0};

    always_comb begin
        // no-op defaults
        ctrl = '{
            alu_op:  alu_add,
            a_sel:   a_rs1,
            b_sel:   b_rs2,
            pc_sel:  pc_plus4,
            br_cond: f3_beq,
            wen:     1'b0,
            rd:      cmd[rd_lsb +: reg_addr_w]
        };
        imm = i_imm;

        case (opcode)
            opc_op: begin
                ctrl.alu_op = alu_op_sel(f3_alu, alt, 1'b1);
                ctrl.wen = 1'b1;
            end
            opc_op_imm: begin
                // shamt sits in imm[4:0]
                ctrl.alu_op = alu_op_sel(f3_alu, alt, 1'b0);
                ctrl.b_sel = b_imm;
                ctrl.wen = 1'b1;
            end
            opc_lui: begin
                ctrl.alu_op = alu_pass_b;
                ctrl.b_sel = b_imm;
                ctrl.wen = 1'b1;
                imm = u_imm;
            end
            opc_auipc: begin
                ctrl.a_sel = a_pc;
                ctrl.b_sel = b_imm;
                ctrl.wen = 1'b1;
                imm = u_imm;
            end
            opc_jal: begin
                // link value pc + 4 through the alu
                ctrl.a_sel = a_pc;
                ctrl.b_sel = b_four;
                ctrl.pc_sel = pc_jal;
                ctrl.wen = 1'b1;
                imm = j_imm;
            end
            opc_jalr: begin
                ctrl.a_sel = a_pc;
                ctrl.b_sel = b_four;
                ctrl.pc_sel = pc_jalr;
                ctrl.wen = 1'b1;
            end
            opc_branch: begin
                ctrl.pc_sel = pc_branch;
                ctrl.br_cond = funct3_branch_e'(cmd[funct3_lsb +: funct3_w]);
                imm = br_imm;
            end
            default: begin
                // unsupported, keep no-op defaults
                ctrl.wen = 1'b0;
            end
        endcase

        // x0 writes dropped here, regfile does not check
        if (ctrl.rd == '0) begin
            ctrl.wen = 1'b0;
        end
    end

endmodule

//--- rv_core_pkg.sv
/* Control and retire types of the single-cycle core. Field order of retire_t is
   wen, rd, data from msb down. */
package rv_core_pkg;

    // enum widths
    localparam int alu_op_w = 4;
    localparam int b_sel_w = 2;
    localparam int pc_sel_w = 2;

    // alu operations
    // pass_b only used by lui
    typedef enum logic [alu_op_w-1:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

    // alu a operand
    typedef enum logic {
        a_rs1 = 1'b0,
        a_pc  = 1'b1
    } a_sel_e;

    // alu b operand
    // constant four gives the link value
    typedef enum logic [b_sel_w-1:0] {
        b_rs2  = 2'd0,
        b_imm  = 2'd1,
        b_four = 2'd2
    } b_sel_e;

    // next pc source
    typedef enum logic [pc_sel_w-1:0] {
        pc_plus4  = 2'd0,
        pc_branch = 2'd1,
        pc_jal    = 2'd2,
        pc_jalr   = 2'd3
    } pc_sel_e;

    // decoded control word, 18 bits
    typedef struct packed {
        alu_op_e                     alu_op;
        a_sel_e                      a_sel;
        b_sel_e                      b_sel;
        pc_sel_e                     pc_sel;
        rv_isa_pkg::funct3_branch_e  br_cond;
        logic                        wen;
        logic [rv_isa_pkg::reg_addr_w-1:0] rd;
    } ctrl_t;

    // one register write per retired instruction, 38 bits
    typedef struct packed {
        logic                        wen;
        logic [rv_isa_pkg::reg_addr_w-1:0] rd;
        logic [rv_isa_pkg::xlen-1:0] data;
    } retire_t;

endpackage

//--- rv_isa_pkg.sv
/* RV32I base encodings only. Loads, stores, fence and system opcodes are not listed
   because the core treats them as no-ops. */
package rv_isa_pkg;

    // data and address width
    localparam int xlen = 32;
    // register index width
    localparam int reg_addr_w = 5;

    localparam int opcode_w = 7;
    localparam int funct3_w = 3;

    // instruction field positions
    localparam int rd_lsb = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb = 15;
    localparam int rs2_lsb = 20;
    // sub and sra select bit in funct7
    localparam int funct7_alt_bit = 30;
    // immediate sign is always in bit 31
    localparam int imm_sign_bit = 31;

    // major opcodes kept by the core
    typedef enum logic [opcode_w-1:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011
    } opcode_e;

    // funct3 of op and op_imm
    typedef enum logic [funct3_w-1:0] {
        f3_add_sub = 3'b000,
        f3_sll     = 3'b001,
        f3_slt     = 3'b010,
        f3_sltu    = 3'b011,
        f3_xor     = 3'b100,
        f3_srl_sra = 3'b101,
        f3_or      = 3'b110,
        f3_and     = 3'b111
    } funct3_alu_e;

    // funct3 of branch
    // 010 and 011 are reserved and never taken
    typedef enum logic [funct3_w-1:0] {
        f3_beq  = 3'b000,
        f3_bne  = 3'b001,
        f3_blt  = 3'b100,
        f3_bge  = 3'b101,
        f3_bltu = 3'b110,
        f3_bgeu = 3'b111
    } funct3_branch_e;

endpackage
